// File: source/cache_types_pkg.sv
// word, line, mask and beat types, line geometry, request and control structs
package cache_types_pkg;

    localparam int s_offset       = 5;  // byte offset bits within a line
    localparam int beats_per_line = 4;
    localparam int line_bytes     = 2**s_offset;

    typedef logic [31:0]                            word_t;
    typedef logic [8*line_bytes-1:0]                line_t;
    typedef logic [line_bytes-1:0]                  byte_mask_t;
    typedef logic [8*line_bytes/beats_per_line-1:0] beat_t;

    typedef struct packed {
        logic       read;
        logic       write;
        word_t      address;
        byte_mask_t byte_enable;
        line_t      wdata;
    } mem_req_t;

    typedef struct packed {
        logic set_dirty;
        logic reset_dirty;
        logic set_valid;
        logic load_tag;
        logic set_lru;
        logic load_data;
        logic pmem_write;   // selects victim address
    } dp_ctrl_t;

    typedef struct packed {
        logic hit;
        logic dirty;        // dirty bit of the lru way
    } dp_status_t;

    typedef enum logic [1:0] {s_idle, s_check, s_writeback, s_fill} cache_state_t;

endpackage

// File: source/data_array.sv
// line storage for one cache way with byte write enables
module data_array
    import cache_types_pkg::*;
#(
    parameter int s_index = 3
)
(
    input  logic               clk,
    input  logic               arst_n,
    input  byte_mask_t         write_en,
    input  logic [s_index-1:0] index,
    input  line_t              datain,
    output line_t              dataout
);

    localparam int num_sets  = 2**s_index;
    localparam int num_bytes = $bits(byte_mask_t);

    line_t data [num_sets];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int s = 0; s < num_sets; s++)
                data[s] <= '0;
        end
        else
        begin
            for (int b = 0; b < num_bytes; b++)
                if (write_en[b])
                    data[index][8*b +: 8] <= datain[8*b +: 8];
        end
    end

    assign dataout = data[index];  // asynchronous read

endmodule

// File: source/meta_array.sv
// per-set storage for tag, valid, dirty or lru bits
module meta_array #(
    parameter int width   = 1,
    parameter int s_index = 3
)
(
    input  logic               clk,
    input  logic               arst_n,
    input  logic               load,
    input  logic [s_index-1:0] index,
    input  logic [width-1:0]   datain,
    output logic [width-1:0]   dataout
);

    localparam int num_sets = 2**s_index;

    logic [width-1:0] data [num_sets];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int s = 0; s < num_sets; s++)
                data[s] <= '0;
        end
        else if (load)
            data[index] <= datain;
    end

    assign dataout = data[index];

endmodule

// File: source/cache_datapath.sv
// hit detection, write enable steering, metadata updates, line mux and memory address
module cache_datapath
    import cache_types_pkg::*;
#(
    parameter int s_index = 3
)
(
    input  logic       clk,
    input  logic       arst_n,
    input  mem_req_t   mem_req,
    input  dp_ctrl_t   dp_ctrl,
    input  line_t      line_rdata,
    output dp_status_t dp_status,
    output line_t      mem_rdata,
    output line_t      line_wdata,
    output word_t      line_address
);

    localparam int s_tag = 32 - s_offset - s_index;

    logic [s_tag-1:0]   req_tag;
    logic [s_index-1:0] req_index;
    logic [s_tag-1:0]   tag_out [2];
    logic [1:0]         valid_out;
    logic [1:0]         dirty_out;
    logic [1:0]         hit_way;
    byte_mask_t         way_we [2];
    line_t              way_data [2];
    line_t              fill_data;
    logic               lru_out;
    logic               lru_in;
    logic               sel_way;

    assign req_tag   = mem_req.address[31 -: s_tag];
    assign req_index = mem_req.address[s_offset +: s_index];

    // cpu data on a write hit, memory line on a fill
    assign fill_data = dp_ctrl.set_dirty ? mem_req.wdata : line_rdata;

    for (genvar w = 0; w < 2; w++)
    begin : way
        logic is_victim;
        logic dirty_load;

        assign is_victim  = (lru_out == 1'(w));
        assign hit_way[w] = valid_out[w] && (tag_out[w] == req_tag);
        assign dirty_load = (dp_ctrl.set_dirty && hit_way[w]) ||
                            (dp_ctrl.reset_dirty && is_victim);

        assign way_we[w] = !dp_ctrl.load_data ? byte_mask_t'('0) :
                           dp_ctrl.set_dirty  ? (hit_way[w] ? mem_req.byte_enable : '0) :
                           (is_victim ? byte_mask_t'('1) : byte_mask_t'('0));

        data_array #(.s_index(s_index)) data_array_inst (
            .clk      (clk),
            .arst_n   (arst_n),
            .write_en (way_we[w]),
            .index    (req_index),
            .datain   (fill_data),
            .dataout  (way_data[w])
        );

        meta_array #(.width(s_tag), .s_index(s_index)) tag_array_inst (
            .clk     (clk),
            .arst_n  (arst_n),
            .load    (dp_ctrl.load_tag && is_victim),
            .index   (req_index),
            .datain  (req_tag),
            .dataout (tag_out[w])
        );

        meta_array #(.width(1), .s_index(s_index)) valid_array_inst (
            .clk     (clk),
            .arst_n  (arst_n),
            .load    (dp_ctrl.set_valid && is_victim),
            .index   (req_index),
            .datain  (1'b1),
            .dataout (valid_out[w])
        );

        meta_array #(.width(1), .s_index(s_index)) dirty_array_inst (
            .clk     (clk),
            .arst_n  (arst_n),
            .load    (dirty_load),
            .index   (req_index),
            .datain  (dp_ctrl.set_dirty),
            .dataout (dirty_out[w])
        );
    end

    // lru bit names the way to replace next
    assign lru_in = hit_way[0];

    meta_array #(.width(1), .s_index(s_index)) lru_array_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .load    (dp_ctrl.set_lru),
        .index   (req_index),
        .datain  (lru_in),
        .dataout (lru_out)
    );

    assign dp_status.hit   = |hit_way;
    assign dp_status.dirty = dirty_out[lru_out];

    assign sel_way    = dp_status.hit ? hit_way[1] : lru_out;  // victim on a miss
    assign mem_rdata  = way_data[sel_way];
    assign line_wdata = way_data[sel_way];

    assign line_address = dp_ctrl.pmem_write ?
                          {tag_out[lru_out], req_index, {s_offset{1'b0}}} :
                          {req_tag, req_index, {s_offset{1'b0}}};

endmodule

// File: source/cache_control.sv
// cache FSM for hit service, write-back and fill
module cache_control
    import cache_types_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  mem_req_t   mem_req,
    input  dp_status_t dp_status,
    input  logic       line_resp,
    output dp_ctrl_t   dp_ctrl,
    output logic       line_read,
    output logic       line_write,
    output logic       mem_resp
);

    cache_state_t state;
    cache_state_t next_state;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            state <= s_idle;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        dp_ctrl    = '0;
        line_read  = 1'b0;
        line_write = 1'b0;
        mem_resp   = 1'b0;

        unique case (state)
            s_idle:
            begin
                if (mem_req.read || mem_req.write)
                    next_state = s_check;
            end

            s_check:
            begin
                if (dp_status.hit)
                begin
                    mem_resp        = 1'b1;
                    dp_ctrl.set_lru = 1'b1;
                    if (mem_req.write)
                    begin
                        dp_ctrl.set_dirty = 1'b1;  // merge under byte mask
                        dp_ctrl.load_data = 1'b1;
                    end
                    next_state = s_idle;
                end
                else if (dp_status.dirty)
                    next_state = s_writeback;
                else
                    next_state = s_fill;
            end

            s_writeback:
            begin
                line_write         = 1'b1;
                dp_ctrl.pmem_write = 1'b1;
                if (line_resp)
                begin
                    dp_ctrl.reset_dirty = 1'b1;
                    next_state          = s_fill;
                end
            end

            s_fill:
            begin
                line_read = 1'b1;
                if (line_resp)
                begin
                    dp_ctrl.load_data = 1'b1;
                    dp_ctrl.load_tag  = 1'b1;
                    dp_ctrl.set_valid = 1'b1;
                    next_state        = s_check;  // retry as a hit
                end
            end

            default: next_state = s_idle;
        endcase
    end

endmodule

// File: source/line_burst_adaptor.sv
// line to four-beat burst conversion with beat counter
module line_burst_adaptor
    import cache_types_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  line_read,
    input  logic  line_write,
    input  word_t line_address,
    input  line_t line_wdata,
    output line_t line_rdata,
    output logic  line_resp,
    output logic  pmem_read,
    output logic  pmem_write,
    output word_t pmem_address,
    output beat_t pmem_wdata,
    input  beat_t pmem_rdata,
    input  logic  pmem_resp
);

    localparam int cnt_bits  = $clog2(beats_per_line);
    localparam int beat_bits = $bits(beat_t);
    localparam logic [cnt_bits-1:0] last_beat = cnt_bits'(beats_per_line - 1);

    logic                busy;
    logic [cnt_bits-1:0] beat_cnt;
    line_t               line_buf;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            busy      <= 1'b0;
            beat_cnt  <= '0;
            line_resp <= 1'b0;
        end
        else
        begin
            line_resp <= 1'b0;
            if (!busy)
            begin
                if ((line_read || line_write) && !line_resp)  // requester still high during resp
                    busy <= 1'b1;
            end
            else if (pmem_resp)
            begin
                beat_cnt <= beat_cnt + 1'b1;
                if (beat_cnt == last_beat)
                begin
                    busy      <= 1'b0;
                    beat_cnt  <= '0;
                    line_resp <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (pmem_read && pmem_resp)
            line_buf[beat_cnt*beat_bits +: beat_bits] <= pmem_rdata;  // low beat first
    end

    assign pmem_read    = busy && line_read;
    assign pmem_write   = busy && line_write;
    assign pmem_address = line_address;
    assign pmem_wdata   = line_wdata[beat_cnt*beat_bits +: beat_bits];
    assign line_rdata   = line_buf;

endmodule

// File: source/cache_top.sv
// cache top level with control, datapath and burst adaptor
module cache_top
    import cache_types_pkg::*;
#(
    parameter int s_index = 3
)
(
    input  logic     clk,
    input  logic     arst_n,
    input  mem_req_t mem_req,
    output line_t    mem_rdata,
    output logic     mem_resp,
    output logic     pmem_read,
    output logic     pmem_write,
    output word_t    pmem_address,
    output beat_t    pmem_wdata,
    input  beat_t    pmem_rdata,
    input  logic     pmem_resp
);

    dp_ctrl_t   dp_ctrl;
    dp_status_t dp_status;
    logic       line_read;
    logic       line_write;
    logic       line_resp;
    word_t      line_address;
    line_t      line_wdata;
    line_t      line_rdata;

    cache_control cache_control_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .mem_req    (mem_req),
        .dp_status  (dp_status),
        .line_resp  (line_resp),
        .dp_ctrl    (dp_ctrl),
        .line_read  (line_read),
        .line_write (line_write),
        .mem_resp   (mem_resp)
    );

    cache_datapath #(.s_index(s_index)) cache_datapath_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .mem_req      (mem_req),
        .dp_ctrl      (dp_ctrl),
        .line_rdata   (line_rdata),
        .dp_status    (dp_status),
        .mem_rdata    (mem_rdata),
        .line_wdata   (line_wdata),
        .line_address (line_address)
    );

    line_burst_adaptor line_burst_adaptor_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .line_read    (line_read),
        .line_write   (line_write),
        .line_address (line_address),
        .line_wdata   (line_wdata),
        .line_rdata   (line_rdata),
        .line_resp    (line_resp),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp)
    );

endmodule

// File: bench/pmem_model.sv
// behavioral burst memory answering beat by beat with random delay
module pmem_model
    import cache_types_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  pmem_read,
    input  logic  pmem_write,
    input  word_t pmem_address,
    input  beat_t pmem_wdata,
    output beat_t pmem_rdata,
    output logic  pmem_resp
);
    timeunit 1ns;
    timeprecision 1ns;

    localparam int num_words = 4096 * 8;  // 4096 lines of 8 words

    word_t       mem [num_words];
    logic [14:0] widx;
    logic [1:0]  beat;
    logic [1:0]  delay;
    logic        waiting;
    integer      seed = 32'h2d3f_6d51;

    initial
    begin
        for (int i = 0; i < num_words; i++)
            mem[i] = 32'(i * 4) ^ 32'ha5a5_0000;  // byte address xor pattern
    end

    assign widx = pmem_address[16:2] + 15'({beat, 1'b0});

    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pmem_rdata <= '0;
            pmem_resp  <= 1'b0;
            beat       <= '0;
            delay      <= '0;
            waiting    <= 1'b0;
        end
        else
        begin
            pmem_resp <= 1'b0;
            if ((pmem_read || pmem_write) && !pmem_resp)
            begin
                if (!waiting)
                begin
                    delay   <= 2'($random(seed));  // 0 to 3 idle cycles
                    waiting <= 1'b1;
                end
                else if (delay != 2'd0)
                    delay <= delay - 2'd1;
                else
                begin
                    if (pmem_read)
                        pmem_rdata <= {mem[widx + 15'd1], mem[widx]};
                    else
                    begin
                        mem[widx]         = pmem_wdata[31:0];
                        mem[widx + 15'd1] = pmem_wdata[63:32];
                    end
                    pmem_resp <= 1'b1;
                    beat      <= beat + 2'd1;  // wraps after the last beat
                    waiting   <= 1'b0;
                end
            end
        end
    end

endmodule

// File: bench/cache_tb.sv
// cache testbench with case file reader, request driver, burst counters and checks
module cache_tb
    import cache_types_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ns;

    localparam int s_index        = 3;
    localparam int timeout_cycles = 200;

    logic     clk;
    logic     arst_n;
    mem_req_t mem_req;
    line_t    mem_rdata;
    logic     mem_resp;
    logic     pmem_read;
    logic     pmem_write;
    word_t    pmem_address;
    beat_t    pmem_wdata;
    beat_t    pmem_rdata;
    logic     pmem_resp;
    integer   fill_cnt   = 0;
    integer   wb_cnt     = 0;
    logic     prev_read  = 1'b0;
    logic     prev_write = 1'b0;

    cache_top #(.s_index(s_index)) cache_top_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .mem_req      (mem_req),
        .mem_rdata    (mem_rdata),
        .mem_resp     (mem_resp),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp)
    );

    pmem_model pmem_model_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // one burst per rising level
    always @(negedge clk)
    begin
        if (pmem_read && !prev_read)
            fill_cnt <= fill_cnt + 1;
        if (pmem_write && !prev_write)
            wb_cnt <= wb_cnt + 1;
        prev_read  <= pmem_read;
        prev_write <= pmem_write;
    end

    task automatic check_line(input line_t got, input line_t exp_line, input integer num);
        if (got !== exp_line)
        begin
            $display("** Error at %0t: case %0d read line %h, expected %h",
                     $time, num, got, exp_line);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic check_count(input integer got, input integer exp_cnt,
                               input integer num, input string what);
        if (got != exp_cnt)
        begin
            $display("** Error at %0t: case %0d caused %0d %s, expected %0d",
                     $time, num, got, what, exp_cnt);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic run_request(input integer num, input integer op, input word_t addr,
                               input byte_mask_t mask, input word_t wword,
                               input line_t exp_line, input integer exp_fills,
                               input integer exp_wbs);
        mem_req_t req;
        integer   fills0;
        integer   wbs0;
        integer   waited;
        line_t    got;

        req.read        = (op == 0);
        req.write       = (op == 1);
        req.address     = addr;
        req.byte_enable = mask;
        req.wdata       = {8{wword}};
        fills0 = fill_cnt;
        wbs0   = wb_cnt;
        waited = 0;

        @(posedge clk);
        mem_req <= req;
        @(negedge clk);
        while (!mem_resp && waited < timeout_cycles)
        begin
            @(negedge clk);
            waited++;
        end
        if (!mem_resp)
        begin
            $display("request %0d to address %h got no response within %0d cycles",
                     num, addr, timeout_cycles);
            $display("sim failed");
            $fatal(1);
        end
        got = mem_rdata;  // line before any merge
        @(posedge clk);
        mem_req <= '0;

        check_line(got, exp_line, num);
        check_count(fill_cnt - fills0, exp_fills, num, "fills");
        check_count(wb_cnt - wbs0, exp_wbs, num, "write-backs");
    endtask

    initial
    begin
        integer     fd;
        integer     n;
        integer     op;
        integer     exp_fills;
        integer     exp_wbs;
        integer     case_num;
        word_t      addr;
        word_t      wword;
        byte_mask_t mask;
        line_t      exp_line;
        string      text;

        mem_req  <= '0;
        arst_n   <= 1'b0;
        case_num = 0;
        fd = $fopen("bench/cache_cases.txt", "r");
        if (fd == 0)
        begin
            $display("could not open bench/cache_cases.txt");
            $display("sim failed");
            $fatal(1);
        end
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        while (!$feof(fd))
        begin
            n = $fgets(text, fd);
            if (n > 0 && text.len() > 1 && text[0] != "#")
            begin
                n = $sscanf(text, "%d %h %h %h %h %d %d", op, addr, mask, wword,
                            exp_line, exp_fills, exp_wbs);
                if (n != 7)
                begin
                    $display("malformed line in case file after case %0d", case_num);
                    $display("sim failed");
                    $fatal(1);
                end
                case_num++;
                run_request(case_num, op, addr, mask, wword, exp_line, exp_fills, exp_wbs);
            end
        end
        $fclose(fd);

        if (case_num == 0)
        begin
            $display("no cases found in bench/cache_cases.txt");
            $display("sim failed");
            $fatal(1);
        end
        else
        begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

// File: bench/cache_cases.txt
# op (0 read, 1 write), address, byte mask, write word copied to all 8 words,
# expected read line (pre-merge for writes), fills and write-backs of this request
# cold miss, hit, partial write and read back in set 2
0 00000040 00000000 00000000 a5a5005ca5a50058a5a50054a5a50050a5a5004ca5a50048a5a50044a5a50040 1 0
0 00000040 00000000 00000000 a5a5005ca5a50058a5a50054a5a50050a5a5004ca5a50048a5a50044a5a50040 0 0
1 00000040 00000f06 11223344 a5a5005ca5a50058a5a50054a5a50050a5a5004ca5a50048a5a50044a5a50040 0 0
0 00000040 00000000 00000000 a5a5005ca5a50058a5a50054a5a50050a5a5004c11223344a5a50044a5223340 0 0
# lru in set 1 with tags 0, 1 and 2
0 00000020 00000000 00000000 a5a5003ca5a50038a5a50034a5a50030a5a5002ca5a50028a5a50024a5a50020 1 0
0 00000120 00000000 00000000 a5a5013ca5a50138a5a50134a5a50130a5a5012ca5a50128a5a50124a5a50120 1 0
0 00000020 00000000 00000000 a5a5003ca5a50038a5a50034a5a50030a5a5002ca5a50028a5a50024a5a50020 0 0
0 00000220 00000000 00000000 a5a5023ca5a50238a5a50234a5a50230a5a5022ca5a50228a5a50224a5a50220 1 0
0 00000020 00000000 00000000 a5a5003ca5a50038a5a50034a5a50030a5a5002ca5a50028a5a50024a5a50020 0 0
0 00000120 00000000 00000000 a5a5013ca5a50138a5a50134a5a50130a5a5012ca5a50128a5a50124a5a50120 1 0
# dirty eviction of 0x40, then clean eviction of 0x140 and re-read of 0x40
0 00000140 00000000 00000000 a5a5015ca5a50158a5a50154a5a50150a5a5014ca5a50148a5a50144a5a50140 1 0
0 00000240 00000000 00000000 a5a5025ca5a50258a5a50254a5a50250a5a5024ca5a50248a5a50244a5a50240 1 1
0 00000040 00000000 00000000 a5a5005ca5a50058a5a50054a5a50050a5a5004c11223344a5a50044a5223340 1 0

// File: sim.f
source/cache_types_pkg.sv
source/data_array.sv
source/meta_array.sv
source/cache_datapath.sv
source/cache_control.sv
source/line_burst_adaptor.sv
source/cache_top.sv
bench/pmem_model.sv
bench/cache_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = cache_tb
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
